//--- Makefile
VERILATOR ?= verilator
TOP       ?= exe_stage_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "Failure reported in $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "Run ended early, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/csr_exec.sv
`timescale 1ns/1ns

module csr_exec (
    exe_operand_if.sink ops,
    input  exe_pkg::csr_op_t   csr_op,
    input  exe_pkg::csr_asel_t csr_asel,
    input  exe_pkg::csr_bsel_t csr_bsel,
    output exe_pkg::data_t     csr_res
);

    exe_pkg::reg_idx_t rs1_idx;
    exe_pkg::data_t    csr_a;
    exe_pkg::data_t    csr_b;

    // rs1 field doubles as the 5-bit immediate of csrrwi and friends
    assign rs1_idx = ops.inst[19:15];

    assign csr_a = (csr_asel == exe_pkg::csr_asel_csr) ? ops.csr_val : '0;

    always_comb begin
        case (csr_bsel)
            exe_pkg::csr_bsel_rs1:  csr_b = ops.rs1_data;
            exe_pkg::csr_bsel_uimm: csr_b = exe_pkg::data_t'(rs1_idx);
            default:                csr_b = '0;
        endcase
    end

    always_comb begin
        case (csr_op)
            exe_pkg::csr_add:    csr_res = csr_a + csr_b;
            exe_pkg::csr_or:     csr_res = csr_a | csr_b;
            exe_pkg::csr_andnot: csr_res = csr_a & ~csr_b;
            default:             csr_res = '0;
        endcase
    end

endmodule

//--- hdl/exe_commit.sv
`timescale 1ns/1ns

module exe_commit (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  logic                hold,
    input  logic                flush,
    input  exe_pkg::data_t      pc,
    input  exe_pkg::inst_t      inst,
    input  exe_pkg::exe_ctrl_t  ctrl,
    input  exe_pkg::data_t      alu_res,
    input  exe_pkg::data_t      csr_res,
    input  exe_pkg::data_t      csr_val,
    input  logic                br_taken,
    output logic                out_valid,
    output logic                out_redirect,
    output logic                out_we_reg,
    output exe_pkg::reg_idx_t   out_rd,
    output exe_pkg::data_t      out_pc,
    output exe_pkg::data_t      out_result,
    output exe_pkg::data_t      out_csr_result,
    output exe_pkg::data_t      out_npc
);

    logic           is_csr;
    logic           redirect;
    exe_pkg::data_t result;
    exe_pkg::data_t npc;

    assign is_csr = (inst[6:0] == exe_pkg::opcode_system) && (inst[14:12] != 3'b000);

    // CSR instructions write the old CSR value to rd
    assign result   = is_csr ? csr_val : alu_res;
    assign redirect = ctrl.npc_sel | br_taken;
    assign npc      = redirect ? alu_res : pc + exe_pkg::data_t'(4);

    // Flush wins over hold, an idle edge loads a bubble
    always_ff @(posedge clk) begin
        if (rst || flush || (!hold && !in_valid)) begin
            out_valid      <= 1'b0;
            out_redirect   <= 1'b0;
            out_we_reg     <= 1'b0;
            out_rd         <= '0;
            out_pc         <= '0;
            out_result     <= '0;
            out_csr_result <= '0;
            out_npc        <= '0;
        end else if (!hold) begin
            out_valid      <= 1'b1;
            out_redirect   <= redirect;
            out_we_reg     <= ctrl.we_reg;
            out_rd         <= ctrl.rd;
            out_pc         <= pc;
            out_result     <= result;
            out_csr_result <= csr_res;
            out_npc        <= npc;
        end
    end

endmodule

//--- hdl/exe_operand_if.sv
`timescale 1ns/1ns

// Operands of the instruction currently in execute
interface exe_operand_if;
    exe_pkg::data_t pc;
    exe_pkg::inst_t inst;
    exe_pkg::data_t rs1_data;
    exe_pkg::data_t rs2_data;
    exe_pkg::data_t imm;
    exe_pkg::data_t csr_val;

    modport src (
        output pc, inst, rs1_data, rs2_data, imm, csr_val
    );

    modport sink (
        input pc, inst, rs1_data, rs2_data, imm, csr_val
    );
endinterface

//--- hdl/exe_pkg.sv
package exe_pkg;

    localparam int xlen = 64;
    localparam int ilen = 32;
    localparam int reg_idx_w = 5;
    localparam int shamt_w = 6;

    // CSR instructions use SYSTEM with a nonzero funct3
    localparam logic [6:0] opcode_system = 7'b1110011;

    typedef logic [xlen-1:0] data_t;
    typedef logic [ilen-1:0] inst_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
    } alu_op_t;

    typedef enum logic [2:0] {
        cmp_none, cmp_eq, cmp_ne, cmp_lt, cmp_ge, cmp_ltu, cmp_geu
    } cmp_op_t;

    typedef enum logic [1:0] {
        asel_zero, asel_rs1, asel_pc
    } alu_asel_t;

    typedef enum logic [1:0] {
        bsel_zero, bsel_rs2, bsel_imm
    } alu_bsel_t;

    typedef enum logic [1:0] {
        csr_add, csr_or, csr_andnot
    } csr_op_t;

    typedef enum logic {
        csr_asel_zero, csr_asel_csr
    } csr_asel_t;

    typedef enum logic [1:0] {
        csr_bsel_zero, csr_bsel_rs1, csr_bsel_uimm
    } csr_bsel_t;

    // Control bundle of one decoded instruction
    typedef struct packed {
        alu_op_t   alu_op;
        cmp_op_t   cmp_op;
        alu_asel_t alu_asel;
        alu_bsel_t alu_bsel;
        csr_op_t   csr_op;
        csr_asel_t csr_asel;
        csr_bsel_t csr_bsel;
        logic      npc_sel;
        reg_idx_t  rd;
        logic      we_reg;
    } exe_ctrl_t;

endpackage

//--- hdl/exe_stage.sv
`timescale 1ns/1ns

module exe_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  logic                hold,
    input  logic                flush,
    input  exe_pkg::data_t      pc,
    input  exe_pkg::inst_t      inst,
    input  exe_pkg::data_t      rs1_data,
    input  exe_pkg::data_t      rs2_data,
    input  exe_pkg::data_t      imm,
    input  exe_pkg::data_t      csr_val,
    input  exe_pkg::exe_ctrl_t  ctrl,
    output logic                out_valid,
    output logic                out_redirect,
    output logic                out_we_reg,
    output exe_pkg::reg_idx_t   out_rd,
    output exe_pkg::data_t      out_pc,
    output exe_pkg::data_t      out_result,
    output exe_pkg::data_t      out_csr_result,
    output exe_pkg::data_t      out_npc
);

    exe_pkg::data_t alu_res;
    exe_pkg::data_t csr_res;
    logic           br_taken;

    exe_operand_if ops ();

    assign ops.pc       = pc;
    assign ops.inst     = inst;
    assign ops.rs1_data = rs1_data;
    assign ops.rs2_data = rs2_data;
    assign ops.imm      = imm;
    assign ops.csr_val  = csr_val;

    int_exec int_exec_i (
        .ops      (ops.sink),
        .alu_op   (ctrl.alu_op),
        .asel     (ctrl.alu_asel),
        .bsel     (ctrl.alu_bsel),
        .cmp_op   (ctrl.cmp_op),
        .alu_res  (alu_res),
        .br_taken (br_taken)
    );

    csr_exec csr_exec_i (
        .ops      (ops.sink),
        .csr_op   (ctrl.csr_op),
        .csr_asel (ctrl.csr_asel),
        .csr_bsel (ctrl.csr_bsel),
        .csr_res  (csr_res)
    );

    exe_commit exe_commit_i (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .hold           (hold),
        .flush          (flush),
        .pc             (pc),
        .inst           (inst),
        .ctrl           (ctrl),
        .alu_res        (alu_res),
        .csr_res        (csr_res),
        .csr_val        (csr_val),
        .br_taken       (br_taken),
        .out_valid      (out_valid),
        .out_redirect   (out_redirect),
        .out_we_reg     (out_we_reg),
        .out_rd         (out_rd),
        .out_pc         (out_pc),
        .out_result     (out_result),
        .out_csr_result (out_csr_result),
        .out_npc        (out_npc)
    );

endmodule

//--- hdl/int_exec.sv
`timescale 1ns/1ns

module int_exec (
    exe_operand_if.sink ops,
    input  exe_pkg::alu_op_t   alu_op,
    input  exe_pkg::alu_asel_t asel,
    input  exe_pkg::alu_bsel_t bsel,
    input  exe_pkg::cmp_op_t   cmp_op,
    output exe_pkg::data_t     alu_res,
    output logic               br_taken
);

    exe_pkg::data_t alu_a;
    exe_pkg::data_t alu_b;
    logic [exe_pkg::shamt_w-1:0] shamt;

    always_comb begin
        case (asel)
            exe_pkg::asel_rs1: alu_a = ops.rs1_data;
            exe_pkg::asel_pc:  alu_a = ops.pc;
            default:           alu_a = '0;
        endcase
    end

    always_comb begin
        case (bsel)
            exe_pkg::bsel_rs2: alu_b = ops.rs2_data;
            exe_pkg::bsel_imm: alu_b = ops.imm;
            default:           alu_b = '0;
        endcase
    end

    // RV64 shifts only look at the low six bits
    assign shamt = alu_b[exe_pkg::shamt_w-1:0];

    always_comb begin
        case (alu_op)
            exe_pkg::alu_add:  alu_res = alu_a + alu_b;
            exe_pkg::alu_sub:  alu_res = alu_a - alu_b;
            exe_pkg::alu_and:  alu_res = alu_a & alu_b;
            exe_pkg::alu_or:   alu_res = alu_a | alu_b;
            exe_pkg::alu_xor:  alu_res = alu_a ^ alu_b;
            exe_pkg::alu_slt: begin
                alu_res = exe_pkg::data_t'($signed(alu_a) < $signed(alu_b));
            end
            exe_pkg::alu_sltu: alu_res = exe_pkg::data_t'(alu_a < alu_b);
            exe_pkg::alu_sll:  alu_res = alu_a << shamt;
            exe_pkg::alu_srl:  alu_res = alu_a >> shamt;
            exe_pkg::alu_sra: begin
                alu_res = exe_pkg::data_t'($signed(alu_a) >>> shamt);
            end
            default:           alu_res = '0;
        endcase
    end

    // Branch compare always works on the register values
    always_comb begin
        case (cmp_op)
            exe_pkg::cmp_eq:  br_taken = (ops.rs1_data == ops.rs2_data);
            exe_pkg::cmp_ne:  br_taken = (ops.rs1_data != ops.rs2_data);
            exe_pkg::cmp_lt:  br_taken = ($signed(ops.rs1_data) < $signed(ops.rs2_data));
            exe_pkg::cmp_ge:  br_taken = ($signed(ops.rs1_data) >= $signed(ops.rs2_data));
            exe_pkg::cmp_ltu: br_taken = (ops.rs1_data < ops.rs2_data);
            exe_pkg::cmp_geu: br_taken = (ops.rs1_data >= ops.rs2_data);
            default:          br_taken = 1'b0;
        endcase
    end

endmodule

//--- sim.f
hdl/exe_pkg.sv
hdl/exe_operand_if.sv
hdl/int_exec.sv
hdl/csr_exec.sv
hdl/exe_commit.sv
hdl/exe_stage.sv
verif/tb_clock.sv
verif/exe_stage_properties.sv
verif/exe_stage_tb.sv

//--- verif/exe_stage_properties.sv
`timescale 1ns/1ns

module exe_stage_properties (
    input logic              clk,
    input logic              rst,
    input logic              hold,
    input logic              flush,
    input logic              out_valid,
    input logic              out_redirect,
    input logic              out_we_reg,
    input exe_pkg::reg_idx_t out_rd,
    input exe_pkg::data_t    out_pc,
    input exe_pkg::data_t    out_result,
    input exe_pkg::data_t    out_csr_result,
    input exe_pkg::data_t    out_npc
);

    // Reset or flush always leaves a bubble behind
    reset_flush_clears: assert property (
        @(posedge clk) (rst || flush) |=> !out_valid
    ) else $error("out_valid high in the cycle after reset or flush");

    hold_keeps_outputs: assert property (
        @(posedge clk) (!rst && !flush && hold) |=>
            $stable({out_valid, out_redirect, out_we_reg, out_rd,
                     out_pc, out_result, out_csr_result, out_npc})
    ) else $error("EXE/MEM outputs changed across a hold");

    redirect_needs_valid: assert property (
        @(posedge clk) out_redirect |-> out_valid
    ) else $error("out_redirect high while out_valid is low");

endmodule

//--- verif/exe_stage_tb.sv
`timescale 1ns/1ns

module exe_stage_tb;

    typedef struct packed {
        logic              valid;
        logic              redirect;
        logic              we_reg;
        exe_pkg::reg_idx_t rd;
        exe_pkg::data_t    pc;
        exe_pkg::data_t    result;
        exe_pkg::data_t    csr_result;
        exe_pkg::data_t    npc;
    } out_rec_t;

    // Reset, ALU sweep, branches, CSR sweep, directed edges, random hold mix
    localparam int n_cycles = 5 + 90 + 60 + 36 + 4 + 100;
    localparam int limit_ns = n_cycles * 4 + 200;

    bit                  clk;
    logic                rst;
    logic                in_valid;
    logic                hold;
    logic                flush;
    exe_pkg::data_t      pc;
    exe_pkg::inst_t      inst;
    exe_pkg::data_t      rs1_data;
    exe_pkg::data_t      rs2_data;
    exe_pkg::data_t      imm;
    exe_pkg::data_t      csr_val;
    exe_pkg::exe_ctrl_t  ctrl;
    logic                out_valid;
    logic                out_redirect;
    logic                out_we_reg;
    exe_pkg::reg_idx_t   out_rd;
    exe_pkg::data_t      out_pc;
    exe_pkg::data_t      out_result;
    exe_pkg::data_t      out_csr_result;
    exe_pkg::data_t      out_npc;

    out_rec_t expected_q[$];
    out_rec_t last_exp;
    int       errors;

    tb_clock clock_i (.clk(clk));

    exe_stage dut_i (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .hold           (hold),
        .flush          (flush),
        .pc             (pc),
        .inst           (inst),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .imm            (imm),
        .csr_val        (csr_val),
        .ctrl           (ctrl),
        .out_valid      (out_valid),
        .out_redirect   (out_redirect),
        .out_we_reg     (out_we_reg),
        .out_rd         (out_rd),
        .out_pc         (out_pc),
        .out_result     (out_result),
        .out_csr_result (out_csr_result),
        .out_npc        (out_npc)
    );

    bind exe_commit exe_stage_properties props_i (
        .clk            (clk),
        .rst            (rst),
        .hold           (hold),
        .flush          (flush),
        .out_valid      (out_valid),
        .out_redirect   (out_redirect),
        .out_we_reg     (out_we_reg),
        .out_rd         (out_rd),
        .out_pc         (out_pc),
        .out_result     (out_result),
        .out_csr_result (out_csr_result),
        .out_npc        (out_npc)
    );

    // Expected EXE/MEM contents for one accepted instruction
    function automatic out_rec_t model_item(
        input exe_pkg::data_t     pc_v,
        input exe_pkg::inst_t     inst_v,
        input exe_pkg::data_t     rs1_v,
        input exe_pkg::data_t     rs2_v,
        input exe_pkg::data_t     imm_v,
        input exe_pkg::data_t     csr_v,
        input exe_pkg::exe_ctrl_t c
    );
        exe_pkg::data_t a;
        exe_pkg::data_t b;
        exe_pkg::data_t alu;
        exe_pkg::data_t ca;
        exe_pkg::data_t cb;
        logic           lt_s;
        logic           lt_u;
        logic           taken;
        out_rec_t       r;
        a = (c.alu_asel == exe_pkg::asel_rs1) ? rs1_v :
            (c.alu_asel == exe_pkg::asel_pc) ? pc_v : '0;
        b = (c.alu_bsel == exe_pkg::bsel_rs2) ? rs2_v :
            (c.alu_bsel == exe_pkg::bsel_imm) ? imm_v : '0;
        case (c.alu_op)
            exe_pkg::alu_add:  alu = a + b;
            exe_pkg::alu_sub:  alu = a + ~b + 64'd1;
            exe_pkg::alu_and:  alu = a & b;
            exe_pkg::alu_or:   alu = a | b;
            exe_pkg::alu_xor:  alu = a ^ b;
            exe_pkg::alu_slt:  alu = {63'b0, $signed(a) < $signed(b)};
            exe_pkg::alu_sltu: alu = {63'b0, a < b};
            exe_pkg::alu_sll:  alu = a << b[5:0];
            exe_pkg::alu_srl:  alu = a >> b[5:0];
            exe_pkg::alu_sra:  alu = $signed(a) >>> b[5:0];
            default:           alu = '0;
        endcase
        lt_s = $signed(rs1_v) < $signed(rs2_v);
        lt_u = rs1_v < rs2_v;
        case (c.cmp_op)
            exe_pkg::cmp_eq:  taken = (rs1_v == rs2_v);
            exe_pkg::cmp_ne:  taken = (rs1_v != rs2_v);
            exe_pkg::cmp_lt:  taken = lt_s;
            exe_pkg::cmp_ge:  taken = !lt_s;
            exe_pkg::cmp_ltu: taken = lt_u;
            exe_pkg::cmp_geu: taken = !lt_u;
            default:          taken = 1'b0;
        endcase
        ca = (c.csr_asel == exe_pkg::csr_asel_csr) ? csr_v : '0;
        cb = (c.csr_bsel == exe_pkg::csr_bsel_rs1) ? rs1_v :
             (c.csr_bsel == exe_pkg::csr_bsel_uimm) ? {59'b0, inst_v[19:15]} : '0;
        r.valid      = 1'b1;
        r.redirect   = c.npc_sel | taken;
        r.we_reg     = c.we_reg;
        r.rd         = c.rd;
        r.pc         = pc_v;
        r.npc        = r.redirect ? alu : pc_v + 64'd4;
        r.csr_result = (c.csr_op == exe_pkg::csr_add) ? ca + cb :
                       (c.csr_op == exe_pkg::csr_or) ? ca | cb : ca & ~cb;
        if (inst_v[6:0] == exe_pkg::opcode_system && inst_v[14:12] != 3'b000) begin
            r.result = csr_v;
        end else begin
            r.result = alu;
        end
        return r;
    endfunction

    task automatic rand_operands(input logic csr_kind);
        pc       = {$urandom, $urandom};
        inst     = $urandom;
        rs1_data = {$urandom, $urandom};
        rs2_data = {$urandom, $urandom};
        imm      = {$urandom, $urandom};
        csr_val  = {$urandom, $urandom};
        if (csr_kind) begin
            inst[6:0]   = exe_pkg::opcode_system;
            inst[14:12] = 3'($urandom_range(1, 7));
        end else if ($urandom_range(0, 3) == 0) begin
            // SYSTEM with funct3 zero is not a CSR instruction
            inst[6:0]   = exe_pkg::opcode_system;
            inst[14:12] = 3'b000;
        end else if (inst[6:0] == exe_pkg::opcode_system) begin
            inst[6:0] = 7'b0010011;
        end
        ctrl.alu_op   = exe_pkg::alu_op_t'($urandom_range(0, 9));
        ctrl.cmp_op   = exe_pkg::cmp_op_t'($urandom_range(0, 6));
        ctrl.alu_asel = exe_pkg::alu_asel_t'($urandom_range(0, 2));
        ctrl.alu_bsel = exe_pkg::alu_bsel_t'($urandom_range(0, 2));
        ctrl.csr_op   = exe_pkg::csr_op_t'($urandom_range(0, 2));
        ctrl.csr_asel = exe_pkg::csr_asel_t'($urandom_range(0, 1));
        ctrl.csr_bsel = exe_pkg::csr_bsel_t'($urandom_range(0, 2));
        ctrl.npc_sel  = 1'($urandom);
        ctrl.rd       = 5'($urandom);
        ctrl.we_reg   = 1'($urandom);
    endtask

    // Drive one edge worth of control and queue what the register should hold after it
    task automatic step(input logic v, input logic h, input logic f);
        out_rec_t nxt;
        in_valid = v;
        hold     = h;
        flush    = f;
        if (rst || f) begin
            nxt = '0;
        end else if (h) begin
            nxt = last_exp;
        end else if (!v) begin
            nxt = '0;
        end else begin
            nxt = model_item(pc, inst, rs1_data, rs2_data, imm, csr_val, ctrl);
        end
        last_exp = nxt;
        expected_q.push_back(nxt);
        @(negedge clk);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        errors++;
        $display("Fail %s: got %h, expected %h", name, got, want);
        $display("Simulation FAILED");
        $fatal(1, "Output mismatch");
    endtask

    task automatic check_outputs(input out_rec_t e);
        assert (out_valid === e.valid)
            else report_mismatch("out_valid", 64'(out_valid), 64'(e.valid));
        assert (out_redirect === e.redirect)
            else report_mismatch("out_redirect", 64'(out_redirect), 64'(e.redirect));
        assert (out_we_reg === e.we_reg)
            else report_mismatch("out_we_reg", 64'(out_we_reg), 64'(e.we_reg));
        assert (out_rd === e.rd)
            else report_mismatch("out_rd", 64'(out_rd), 64'(e.rd));
        assert (out_pc === e.pc)
            else report_mismatch("out_pc", out_pc, e.pc);
        assert (out_result === e.result)
            else report_mismatch("out_result", out_result, e.result);
        assert (out_csr_result === e.csr_result)
            else report_mismatch("out_csr_result", out_csr_result, e.csr_result);
        assert (out_npc === e.npc)
            else report_mismatch("out_npc", out_npc, e.npc);
    endtask

    // Sample 1 ns after the rising edge while inputs wait for the falling edge
    initial begin
        out_rec_t e;
        forever begin
            @(posedge clk);
            #1;
            if (expected_q.size() > 0) begin
                e = expected_q.pop_front();
                check_outputs(e);
            end
        end
    end

    initial begin
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("Simulation FAILED");
        $fatal(1, "Timeout");
    end

    initial begin
        void'($urandom(71554));
        errors   = 0;
        last_exp = '0;
        rst      = 1'b1;
        in_valid = 1'b0;
        hold     = 1'b0;
        flush    = 1'b0;
        pc       = '0;
        inst     = '0;
        rs1_data = '0;
        rs2_data = '0;
        imm      = '0;
        csr_val  = '0;
        ctrl     = '0;
        for (int i = 0; i < 5; i++) begin
            step(1'b0, 1'b0, 1'b0);
        end
        rst = 1'b0;

        // Every ALU op against every operand source, back to back
        for (int op = 0; op < 10; op++) begin
            for (int a = 0; a < 3; a++) begin
                for (int b = 0; b < 3; b++) begin
                    rand_operands(1'b0);
                    ctrl.alu_op   = exe_pkg::alu_op_t'(op);
                    ctrl.alu_asel = exe_pkg::alu_asel_t'(a);
                    ctrl.alu_bsel = exe_pkg::alu_bsel_t'(b);
                    ctrl.cmp_op   = exe_pkg::cmp_none;
                    ctrl.npc_sel  = 1'b0;
                    step(1'b1, 1'b0, 1'b0);
                end
            end
        end

        // Branch target is pc plus imm with equal operands now and then
        for (int i = 0; i < 60; i++) begin
            rand_operands(1'b0);
            ctrl.alu_op   = exe_pkg::alu_add;
            ctrl.alu_asel = exe_pkg::asel_pc;
            ctrl.alu_bsel = exe_pkg::bsel_imm;
            if ($urandom_range(0, 3) == 0) begin
                rs2_data = rs1_data;
            end
            step(1'b1, 1'b0, 1'b0);
        end

        for (int rep = 0; rep < 2; rep++) begin
            for (int op = 0; op < 3; op++) begin
                for (int a = 0; a < 2; a++) begin
                    for (int b = 0; b < 3; b++) begin
                        rand_operands(1'b1);
                        ctrl.csr_op   = exe_pkg::csr_op_t'(op);
                        ctrl.csr_asel = exe_pkg::csr_asel_t'(a);
                        ctrl.csr_bsel = exe_pkg::csr_bsel_t'(b);
                        step(1'b1, 1'b0, 1'b0);
                    end
                end
            end
        end

        // Flush under hold, then an idle edge
        rand_operands(1'b0);
        step(1'b1, 1'b0, 1'b0);
        step(1'b1, 1'b1, 1'b1);
        step(1'b1, 1'b1, 1'b0);
        step(1'b0, 1'b0, 1'b0);

        for (int i = 0; i < 100; i++) begin
            rand_operands(1'($urandom_range(0, 3) == 0));
            step(1'($urandom_range(0, 3) != 0), 1'($urandom_range(0, 2) == 0),
                 1'($urandom_range(0, 9) == 0));
        end

        while (expected_q.size() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ns

// Free-running 4 ns clock, starts low
module tb_clock (
    output bit clk
);

    always #2 clk = ~clk;

endmodule
